/* verilog/lc4_macros.svh */
// Datapath width, register file size, boot PC and NOP encoding defines
`ifndef LC4_MACROS_SVH
`define LC4_MACROS_SVH

// Data and address width
`define LC4_XLEN 16

// Register file geometry
`define LC4_NREG 8
`define LC4_RSEL_W 3

// First fetch address after reset
`define LC4_RESET_PC 16'h8200

// BR with no condition bits, used as the bubble word
`define LC4_NOP 16'h0000

`endif

/* verilog/lc4_pkg.sv */
// LC4 opcode and ALU operation enumerations
package lc4_pkg;

   // Major opcode in instruction bits 15:12
   typedef enum logic [3:0] {
      OP_NOP   = 4'b0000,  // BR, only the empty form is kept
      OP_ARITH = 4'b0001,
      OP_LOGIC = 4'b0101,
      OP_LDR   = 4'b0110,
      OP_STR   = 4'b0111,
      OP_CONST = 4'b1001
   } lc4_opcode_e;

   // Operation selected for the execute stage
   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      ALU_SUB    = 3'd1,
      ALU_AND    = 3'd2,
      ALU_OR     = 3'd3,
      ALU_XOR    = 3'd4,
      ALU_PASS_B = 3'd5,  // CONST immediate straight through
      ALU_NONE   = 3'd6   // NOP and unsupported encodings
   } lc4_aluop_e;

endpackage

/* verilog/lc4_decoder.sv */
// LC4 instruction decoder for the arith, logic, load, store and CONST subset
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_decoder (
   input  logic [`LC4_XLEN-1:0]   i_insn,
   output logic [`LC4_RSEL_W-1:0] o_rs_sel,
   output logic [`LC4_RSEL_W-1:0] o_rt_sel,
   output logic [`LC4_RSEL_W-1:0] o_rd_sel,
   output logic                   o_rs_re,
   output logic                   o_rt_re,
   output logic                   o_rd_we,
   output logic                   o_is_load,
   output logic                   o_is_store,
   output lc4_pkg::lc4_aluop_e    o_aluop,
   output logic                   o_use_imm,
   output logic [`LC4_XLEN-1:0]   o_imm
);

   logic [`LC4_XLEN-1:0] imm5;
   logic [`LC4_XLEN-1:0] imm6;
   logic [`LC4_XLEN-1:0] imm9;
   logic                 rr_op;  // Register-register form
   logic                 ri_op;  // Register-imm5 form

   assign imm5 = {{(`LC4_XLEN-5){i_insn[4]}}, i_insn[4:0]};
   assign imm6 = {{(`LC4_XLEN-6){i_insn[5]}}, i_insn[5:0]};
   assign imm9 = {{(`LC4_XLEN-9){i_insn[8]}}, i_insn[8:0]};

   // Fixed field positions, STR takes its data register from the rd slot
   assign o_rs_sel = i_insn[8:6];
   assign o_rd_sel = i_insn[11:9];
   assign o_rt_sel = (i_insn[15:12] == lc4_pkg::OP_STR) ? i_insn[11:9] : i_insn[2:0];

   always_comb begin
      o_rs_re    = 1'b0;
      o_rt_re    = 1'b0;
      o_rd_we    = 1'b0;
      o_is_load  = 1'b0;
      o_is_store = 1'b0;
      o_use_imm  = 1'b0;
      o_imm      = '0;
      o_aluop    = lc4_pkg::ALU_NONE;
      rr_op      = 1'b0;
      ri_op      = 1'b0;

      case (lc4_pkg::lc4_opcode_e'(i_insn[15:12]))
         lc4_pkg::OP_ARITH: begin
            if (i_insn[5]) begin
               ri_op   = 1'b1;
               o_aluop = lc4_pkg::ALU_ADD;
            end else begin
               case (i_insn[4:3])
                  2'b00: begin
                     rr_op   = 1'b1;
                     o_aluop = lc4_pkg::ALU_ADD;
                  end
                  2'b10: begin
                     rr_op   = 1'b1;
                     o_aluop = lc4_pkg::ALU_SUB;
                  end
                  default: o_aluop = lc4_pkg::ALU_NONE;  // MUL, DIV
               endcase
            end
         end
         lc4_pkg::OP_LOGIC: begin
            if (i_insn[5]) begin
               ri_op   = 1'b1;
               o_aluop = lc4_pkg::ALU_AND;
            end else begin
               rr_op = (i_insn[4:3] != 2'b01);  // NOT is not kept
               case (i_insn[4:3])
                  2'b00:   o_aluop = lc4_pkg::ALU_AND;
                  2'b10:   o_aluop = lc4_pkg::ALU_OR;
                  2'b11:   o_aluop = lc4_pkg::ALU_XOR;
                  default: o_aluop = lc4_pkg::ALU_NONE;
               endcase
            end
         end
         lc4_pkg::OP_LDR: begin
            o_is_load = 1'b1;
            o_rs_re   = 1'b1;
            o_rd_we   = 1'b1;
            o_use_imm = 1'b1;
            o_imm     = imm6;
            o_aluop   = lc4_pkg::ALU_ADD;   // Base plus offset
         end
         lc4_pkg::OP_STR: begin
            o_is_store = 1'b1;
            o_rs_re    = 1'b1;
            o_rt_re    = 1'b1;
            o_use_imm  = 1'b1;
            o_imm      = imm6;
            o_aluop    = lc4_pkg::ALU_ADD;
         end
         lc4_pkg::OP_CONST: begin
            o_rd_we   = 1'b1;
            o_use_imm = 1'b1;
            o_imm     = imm9;
            o_aluop   = lc4_pkg::ALU_PASS_B;
         end
         default: o_aluop = lc4_pkg::ALU_NONE;  // NOP and dropped opcodes
      endcase

      if (rr_op) begin
         o_rs_re = 1'b1;
         o_rt_re = 1'b1;
         o_rd_we = 1'b1;
      end
      if (ri_op) begin
         o_rs_re   = 1'b1;
         o_rd_we   = 1'b1;
         o_use_imm = 1'b1;
         o_imm     = imm5;
      end
   end

endmodule

/* verilog/lc4_regfile.sv */
// Eight-entry register file with two read ports and write-through forwarding
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_regfile (
   input  logic                   gwe,
   input  logic                   i_arst_n,
   input  logic [`LC4_RSEL_W-1:0] i_rs_sel,
   input  logic [`LC4_RSEL_W-1:0] i_rt_sel,
   input  logic [`LC4_RSEL_W-1:0] i_rd_sel,
   input  logic                   i_rd_we,
   input  logic [`LC4_XLEN-1:0]   i_wdata,
   output logic [`LC4_XLEN-1:0]   o_rs_data,
   output logic [`LC4_XLEN-1:0]   o_rt_data
);

   logic [`LC4_XLEN-1:0] regs [`LC4_NREG];
   logic                 rs_hit;
   logic                 rt_hit;

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int i = 0; i < `LC4_NREG; i++) begin
            regs[i] <= '0;
         end
      end else if (i_rd_we) begin
         regs[i_rd_sel] <= i_wdata;
      end
   end

   // Writeback in the same cycle as decode reads wins
   assign rs_hit = i_rd_we && (i_rd_sel == i_rs_sel);
   assign rt_hit = i_rd_we && (i_rd_sel == i_rt_sel);

   assign o_rs_data = rs_hit ? i_wdata : regs[i_rs_sel];
   assign o_rt_data = rt_hit ? i_wdata : regs[i_rt_sel];

   // A write with an unknown target would corrupt an arbitrary register
   assert property (@(posedge gwe) disable iff (!i_arst_n)
      i_rd_we |-> !$isunknown(i_rd_sel))
      else $error("register write with unknown select %b", i_rd_sel);

endmodule

/* verilog/lc4_alu.sv */
// LC4 ALU for add, subtract, logic, CONST pass-through and address generation
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_alu (
   input  lc4_pkg::lc4_aluop_e  i_aluop,
   input  logic                 i_use_imm,
   input  logic [`LC4_XLEN-1:0] i_imm,
   input  logic [`LC4_XLEN-1:0] i_rs_data,
   input  logic [`LC4_XLEN-1:0] i_rt_data,
   output logic [`LC4_XLEN-1:0] o_result
);

   logic [`LC4_XLEN-1:0] operand_b;

   // Immediate forms replace rt as the second operand
   assign operand_b = i_use_imm ? i_imm : i_rt_data;

   // All arithmetic wraps at 16 bits
   always_comb begin
      case (i_aluop)
         lc4_pkg::ALU_ADD:    o_result = i_rs_data + operand_b;  // Also LDR/STR address
         lc4_pkg::ALU_SUB:    o_result = i_rs_data - operand_b;
         lc4_pkg::ALU_AND:    o_result = i_rs_data & operand_b;
         lc4_pkg::ALU_OR:     o_result = i_rs_data | operand_b;
         lc4_pkg::ALU_XOR:    o_result = i_rs_data ^ operand_b;
         lc4_pkg::ALU_PASS_B: o_result = operand_b;              // CONST
         default:             o_result = '0;
      endcase
   end

endmodule

/* verilog/lc4_processor.sv */
// Five-stage LC4 pipeline top level with PC, stage registers, memory port and writeback trace
`timescale 1ns/1ps
`include "lc4_macros.svh"

module lc4_processor (
   input  logic                   gwe,
   input  logic                   i_arst_n,
   output logic [`LC4_XLEN-1:0]   o_cur_pc,
   input  logic [`LC4_XLEN-1:0]   i_cur_insn,
   output logic [`LC4_XLEN-1:0]   o_dmem_addr,
   input  logic [`LC4_XLEN-1:0]   i_cur_dmem_data,
   output logic                   o_dmem_we,
   output logic [`LC4_XLEN-1:0]   o_dmem_towrite,
   output logic [`LC4_XLEN-1:0]   o_wb_pc,
   output logic [`LC4_XLEN-1:0]   o_wb_insn,
   output logic                   o_wb_we,
   output logic [`LC4_RSEL_W-1:0] o_wb_wsel,
   output logic [`LC4_XLEN-1:0]   o_wb_data,
   output logic [2:0]             o_wb_nzp
);

   logic [`LC4_XLEN-1:0] pc_q;

   // Decode stage
   logic [`LC4_XLEN-1:0]   d_pc, d_insn;
   logic [`LC4_RSEL_W-1:0] d_rs_sel, d_rt_sel, d_rd_sel;
   logic                   d_rs_re, d_rt_re, d_rd_we;
   logic                   d_is_load, d_is_store, d_use_imm;
   lc4_pkg::lc4_aluop_e    d_aluop;
   logic [`LC4_XLEN-1:0]   d_imm;
   logic [`LC4_XLEN-1:0]   rf_rs_data, rf_rt_data;
   logic [`LC4_XLEN-1:0]   d_rs_val, d_rt_val;

   // Execute stage
   logic [`LC4_XLEN-1:0]   x_pc, x_insn, x_rs_data, x_rt_data, x_imm;
   logic [`LC4_RSEL_W-1:0] x_rd_sel;
   logic                   x_rd_we, x_is_load, x_is_store, x_use_imm;
   lc4_pkg::lc4_aluop_e    x_aluop;
   logic [`LC4_XLEN-1:0]   x_result;

   // Memory stage
   logic [`LC4_XLEN-1:0]   m_pc, m_insn, m_alu, m_rt_data;
   logic [`LC4_RSEL_W-1:0] m_rd_sel;
   logic                   m_rd_we, m_is_load, m_is_store;

   // Writeback stage
   logic [`LC4_XLEN-1:0]   w_pc, w_insn, w_alu, w_dmem_data, w_wdata;
   logic [`LC4_RSEL_W-1:0] w_rd_sel;
   logic                   w_rd_we, w_is_load;
   logic                   w_neg, w_zero, w_pos;

   // PC only ever steps forward, no control flow is kept
   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc_q <= `LC4_RESET_PC;
      end else begin
         pc_q <= pc_q + 16'd1;
      end
   end

   assign o_cur_pc = pc_q;  // Instruction memory answers in the same cycle

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         d_pc   <= '0;
         d_insn <= `LC4_NOP;
      end else begin
         d_pc   <= pc_q;
         d_insn <= i_cur_insn;
      end
   end

   lc4_decoder u_decoder (
      .i_insn     (d_insn),
      .o_rs_sel   (d_rs_sel),
      .o_rt_sel   (d_rt_sel),
      .o_rd_sel   (d_rd_sel),
      .o_rs_re    (d_rs_re),
      .o_rt_re    (d_rt_re),
      .o_rd_we    (d_rd_we),
      .o_is_load  (d_is_load),
      .o_is_store (d_is_store),
      .o_aluop    (d_aluop),
      .o_use_imm  (d_use_imm),
      .o_imm      (d_imm)
   );

   // Read side sits in decode, write side is driven from writeback
   lc4_regfile u_regfile (
      .gwe       (gwe),
      .i_arst_n  (i_arst_n),
      .i_rs_sel  (d_rs_sel),
      .i_rt_sel  (d_rt_sel),
      .i_rd_sel  (w_rd_sel),
      .i_rd_we   (w_rd_we),
      .i_wdata   (w_wdata),
      .o_rs_data (rf_rs_data),
      .o_rt_data (rf_rt_data)
   );

   // Ports the instruction does not read carry zero down the pipe
   assign d_rs_val = d_rs_re ? rf_rs_data : '0;
   assign d_rt_val = d_rt_re ? rf_rt_data : '0;

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         x_pc       <= '0;
         x_insn     <= `LC4_NOP;
         x_rs_data  <= '0;
         x_rt_data  <= '0;
         x_imm      <= '0;
         x_use_imm  <= 1'b0;
         x_aluop    <= lc4_pkg::ALU_NONE;
         x_rd_sel   <= '0;
         x_rd_we    <= 1'b0;
         x_is_load  <= 1'b0;
         x_is_store <= 1'b0;
      end else begin
         x_pc       <= d_pc;
         x_insn     <= d_insn;
         x_rs_data  <= d_rs_val;
         x_rt_data  <= d_rt_val;
         x_imm      <= d_imm;
         x_use_imm  <= d_use_imm;
         x_aluop    <= d_aluop;
         x_rd_sel   <= d_rd_sel;
         x_rd_we    <= d_rd_we;
         x_is_load  <= d_is_load;
         x_is_store <= d_is_store;
      end
   end

   lc4_alu u_alu (
      .i_aluop   (x_aluop),
      .i_use_imm (x_use_imm),
      .i_imm     (x_imm),
      .i_rs_data (x_rs_data),
      .i_rt_data (x_rt_data),
      .o_result  (x_result)
   );

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         m_pc       <= '0;
         m_insn     <= `LC4_NOP;
         m_alu      <= '0;
         m_rt_data  <= '0;
         m_rd_sel   <= '0;
         m_rd_we    <= 1'b0;
         m_is_load  <= 1'b0;
         m_is_store <= 1'b0;
      end else begin
         m_pc       <= x_pc;
         m_insn     <= x_insn;
         m_alu      <= x_result;
         m_rt_data  <= x_rt_data;
         m_rd_sel   <= x_rd_sel;
         m_rd_we    <= x_rd_we;
         m_is_load  <= x_is_load;
         m_is_store <= x_is_store;
      end
   end

   // Memory port is quiet for everything but loads and stores
   assign o_dmem_we      = m_is_store;
   assign o_dmem_addr    = (m_is_load || m_is_store) ? m_alu : '0;
   assign o_dmem_towrite = m_is_store ? m_rt_data : '0;

   always_ff @(posedge gwe or negedge i_arst_n) begin
      if (!i_arst_n) begin
         w_pc        <= '0;
         w_insn      <= `LC4_NOP;
         w_alu       <= '0;
         w_dmem_data <= '0;
         w_rd_sel    <= '0;
         w_rd_we     <= 1'b0;
         w_is_load   <= 1'b0;
      end else begin
         w_pc        <= m_pc;
         w_insn      <= m_insn;
         w_alu       <= m_alu;
         w_dmem_data <= i_cur_dmem_data;  // Load data captured at end of M
         w_rd_sel    <= m_rd_sel;
         w_rd_we     <= m_rd_we;
         w_is_load   <= m_is_load;
      end
   end

   assign w_wdata = w_is_load ? w_dmem_data : w_alu;

   // Condition bits of the value being written
   assign w_neg  = w_wdata[`LC4_XLEN-1];
   assign w_zero = (w_wdata == '0);
   assign w_pos  = !w_neg && !w_zero;

   assign o_wb_pc   = w_pc;
   assign o_wb_insn = w_insn;
   assign o_wb_we   = w_rd_we;
   assign o_wb_wsel = w_rd_sel;
   assign o_wb_data = w_wdata;
   assign o_wb_nzp  = w_rd_we ? {w_neg, w_zero, w_pos} : 3'b000;

   // Decode and stage registers together must keep a load off the write strobe
   assert property (@(posedge gwe) disable iff (!i_arst_n)
      m_is_load |-> !o_dmem_we)
      else $error("store strobe raised for load at pc %h", m_pc);

endmodule

/* dv/tb_lc4_processor.sv */
// Testbench for the LC4 pipeline with memory models, encoders, reference model and directed tests
`timescale 1ns/1ps
`include "lc4_macros.svh"

module tb_lc4_processor;

   localparam int MAX_CYCLES = 600;  // Six short programs plus reset

   logic        gwe;
   logic        i_arst_n;
   logic [15:0] o_cur_pc, i_cur_insn, o_dmem_addr, i_cur_dmem_data, o_dmem_towrite;
   logic [15:0] o_wb_pc, o_wb_insn, o_wb_data;
   logic        o_dmem_we, o_wb_we;
   logic [2:0]  o_wb_wsel, o_wb_nzp;

   // Program image and per-slot expectations
   logic [15:0] imem [128];
   logic        exp_we [128];
   logic [2:0]  exp_wsel [128];
   logic [15:0] exp_data [128];
   logic        exp_dwe [128];
   logic [15:0] exp_daddr [128];
   logic [15:0] exp_dwr [128];
   logic [15:0] dmem [256];
   logic [15:0] ref_dmem [256];
   logic [15:0] ref_regs [8];
   logic [15:0] fetch_idx;
   int          prog_len;
   int          checks = 0;
   int          errors = 0;
   int          cycle_count = 0;
   integer      seed = 32'hcdc9_fad1;

   lc4_processor u_lc4_processor (.*);

   initial begin
      gwe = 1'b0;
      forever #4 gwe = ~gwe;
   end

   // Combinational instruction memory, NOP past the program
   assign fetch_idx  = o_cur_pc - `LC4_RESET_PC;
   assign i_cur_insn = (fetch_idx < 16'd128) ? imem[fetch_idx[6:0]] : `LC4_NOP;
   assign i_cur_dmem_data = dmem[o_dmem_addr[7:0]];

   always @(posedge gwe) begin
      if (o_dmem_we) dmem[o_dmem_addr[7:0]] <= o_dmem_towrite;
   end

   always @(posedge gwe) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout after %0d cycles, tests did not finish", cycle_count);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   task automatic expect_val(input string name, input logic [15:0] got, input logic [15:0] want);
      checks++;
      if (got !== want) begin
         errors++;
         $display("FAIL t=%0t %s got %h expected %h", $time, name, got, want);
      end
   endtask

   function automatic logic [2:0] sign_bits(input logic [15:0] v);
      if (v[15]) return 3'b100;
      if (v == 16'd0) return 3'b010;
      return 3'b001;
   endfunction

   task automatic new_program();
      for (int i = 0; i < 128; i++) begin
         imem[i]      = `LC4_NOP;
         exp_we[i]    = 1'b0;
         exp_wsel[i]  = 3'd0;
         exp_data[i]  = 16'd0;
         exp_dwe[i]   = 1'b0;
         exp_daddr[i] = 16'd0;
         exp_dwr[i]   = 16'd0;
      end
      for (int r = 0; r < 8; r++) ref_regs[r] = 16'd0;  // Regfile clears on reset
      prog_len = 0;
   endtask

   task automatic raw_word(input logic [15:0] insn);
      imem[prog_len] = insn;
      prog_len++;
   endtask

   task automatic place_nops(input int count);
      repeat (count) raw_word(`LC4_NOP);
   endtask

   task automatic note_write(input logic [2:0] rd, input logic [15:0] val);
      exp_we[prog_len-1]   = 1'b1;
      exp_wsel[prog_len-1] = rd;
      exp_data[prog_len-1] = val;
      ref_regs[rd]         = val;
   endtask

   task automatic load_const(input logic [2:0] rd, input logic [8:0] imm9);
      raw_word({4'b1001, rd, imm9});
      note_write(rd, {{7{imm9[8]}}, imm9});
   endtask

   // ADD, SUB, AND, OR and XOR register forms
   task automatic reg_reg_op(input logic [3:0] op, input logic [2:0] sub,
                             input logic [2:0] rd, input logic [2:0] rs, input logic [2:0] rt);
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] r;
      a = ref_regs[rs];
      b = ref_regs[rt];
      case ({op, sub})
         7'b0001_000: r = a + b;
         7'b0001_010: r = a - b;
         7'b0101_000: r = a & b;
         7'b0101_010: r = a | b;
         default:     r = a ^ b;
      endcase
      raw_word({op, rd, rs, sub, rt});
      note_write(rd, r);
   endtask

   task automatic reg_imm_op(input logic [3:0] op, input logic [2:0] rd, input logic [2:0] rs,
                             input logic [4:0] imm5);
      logic [15:0] b;
      b = {{11{imm5[4]}}, imm5};
      raw_word({op, rd, rs, 1'b1, imm5});
      note_write(rd, (op == 4'b0001) ? ref_regs[rs] + b : ref_regs[rs] & b);
   endtask

   task automatic store_word(input logic [2:0] rt, input logic [2:0] rs, input logic [5:0] imm6);
      logic [15:0] addr;
      addr = ref_regs[rs] + {{10{imm6[5]}}, imm6};
      raw_word({4'b0111, rt, rs, imm6});
      exp_dwe[prog_len-1]   = 1'b1;
      exp_daddr[prog_len-1] = addr;
      exp_dwr[prog_len-1]   = ref_regs[rt];
      ref_dmem[addr[7:0]]   = ref_regs[rt];
   endtask

   task automatic load_word(input logic [2:0] rd, input logic [2:0] rs, input logic [5:0] imm6);
      logic [15:0] addr;
      addr = ref_regs[rs] + {{10{imm6[5]}}, imm6};
      raw_word({4'b0110, rd, rs, imm6});
      exp_daddr[prog_len-1] = addr;
      note_write(rd, ref_dmem[addr[7:0]]);
   endtask

   // Reset, then follow every slot through memory (k-3) and writeback (k-4)
   task automatic run_program(input int len);
      int mslot;
      int wslot;
      @(negedge gwe);
      i_arst_n = 1'b0;
      repeat (2) @(posedge gwe);
      @(negedge gwe);
      expect_val("o_cur_pc", o_cur_pc, `LC4_RESET_PC);
      expect_val("o_dmem_we", 16'(o_dmem_we), 16'd0);
      expect_val("o_dmem_addr", o_dmem_addr, 16'd0);
      expect_val("o_dmem_towrite", o_dmem_towrite, 16'd0);
      expect_val("o_wb_we", 16'(o_wb_we), 16'd0);
      i_arst_n = 1'b1;
      for (int k = 0; k < len + 5; k++) begin
         if (k > 0) @(negedge gwe);
         expect_val("o_cur_pc", o_cur_pc, `LC4_RESET_PC + 16'(k));
         mslot = k - 3;
         wslot = k - 4;
         expect_val("o_dmem_we", 16'(o_dmem_we), (mslot >= 0) ? 16'(exp_dwe[mslot]) : 16'd0);
         expect_val("o_dmem_addr", o_dmem_addr, (mslot >= 0) ? exp_daddr[mslot] : 16'd0);
         expect_val("o_dmem_towrite", o_dmem_towrite, (mslot >= 0) ? exp_dwr[mslot] : 16'd0);
         if (wslot >= 0) begin
            expect_val("o_wb_pc", o_wb_pc, `LC4_RESET_PC + 16'(wslot));
            expect_val("o_wb_insn", o_wb_insn, imem[wslot]);
            expect_val("o_wb_we", 16'(o_wb_we), 16'(exp_we[wslot]));
            if (exp_we[wslot]) begin
               expect_val("o_wb_wsel", 16'(o_wb_wsel), 16'(exp_wsel[wslot]));
               expect_val("o_wb_data", o_wb_data, exp_data[wslot]);
               expect_val("o_wb_nzp", 16'(o_wb_nzp), 16'(sign_bits(exp_data[wslot])));
            end else begin
               expect_val("o_wb_nzp", 16'(o_wb_nzp), 16'd0);
            end
         end else begin
            expect_val("o_wb_we", 16'(o_wb_we), 16'd0);  // Pipeline still full of bubbles
         end
      end
   endtask

   task automatic reset_and_fetch();
      new_program();
      place_nops(6);
      run_program(prog_len);
   endtask

   task automatic arithmetic_ops();
      logic [31:0] rnd;
      rnd = $random(seed);
      new_program();
      load_const(3'd1, rnd[8:0]);
      load_const(3'd2, rnd[24:16]);
      place_nops(2);
      reg_reg_op(4'b0001, 3'b000, 3'd3, 3'd1, 3'd2);
      reg_reg_op(4'b0001, 3'b010, 3'd4, 3'd1, 3'd2);
      reg_imm_op(4'b0001, 3'd5, 3'd2, rnd[31:27]);
      reg_reg_op(4'b0001, 3'b010, 3'd6, 3'd1, 3'd1);  // Zero result
      reg_reg_op(4'b0001, 3'b010, 3'd7, 3'd0, 3'd4);  // r4 three slots back
      run_program(prog_len);
   endtask

   task automatic logic_ops();
      logic [31:0] rnd;
      rnd = $random(seed);
      new_program();
      load_const(3'd1, rnd[8:0]);
      load_const(3'd2, rnd[20:12]);
      place_nops(2);
      reg_reg_op(4'b0101, 3'b000, 3'd3, 3'd1, 3'd2);
      reg_reg_op(4'b0101, 3'b010, 3'd4, 3'd1, 3'd2);
      reg_reg_op(4'b0101, 3'b011, 3'd5, 3'd1, 3'd2);
      reg_imm_op(4'b0101, 3'd6, 3'd1, {1'b1, rnd[27:24]});  // Negative imm5
      run_program(prog_len);
   endtask

   task automatic store_traffic();
      logic [31:0] rnd;
      rnd = $random(seed);
      new_program();
      load_const(3'd1, rnd[8:0]);
      load_const(3'd2, rnd[17:9]);
      place_nops(2);
      store_word(3'd2, 3'd1, rnd[23:18]);
      reg_reg_op(4'b0001, 3'b000, 3'd3, 3'd1, 3'd2);
      store_word(3'd1, 3'd2, {1'b1, rnd[28:24]});
      place_nops(1);
      run_program(prog_len);
   endtask

   task automatic load_forwarding();
      logic [31:0] rnd;
      rnd = $random(seed);
      new_program();
      load_const(3'd1, rnd[8:0]);
      load_const(3'd2, rnd[17:9]);
      place_nops(2);
      store_word(3'd2, 3'd1, rnd[23:18]);
      place_nops(1);
      load_word(3'd3, 3'd1, rnd[23:18]);   // Reads back the store
      load_word(3'd4, 3'd1, rnd[29:24]);   // Fill pattern or earlier store
      place_nops(2);
      reg_reg_op(4'b0001, 3'b000, 3'd5, 3'd3, 3'd4);  // Exactly three after r4
      run_program(prog_len);
   endtask

   task automatic unsupported_opcodes();
      logic [31:0] rnd;
      rnd = $random(seed);
      new_program();
      load_const(3'd1, rnd[8:0]);
      load_const(3'd2, rnd[18:10]);
      raw_word({4'b1100, 3'b000, 3'd1, 6'd0});          // JMP R1
      raw_word({4'b0001, 3'd3, 3'd1, 3'b001, 3'd2});    // MUL R3
      reg_reg_op(4'b0001, 3'b000, 3'd4, 3'd1, 3'd2);
      place_nops(1);
      reg_reg_op(4'b0001, 3'b000, 3'd5, 3'd3, 3'd3);  // R3 must still be zero
      run_program(prog_len);
   endtask

   initial begin
      i_arst_n = 1'b0;
      for (int a = 0; a < 256; a++) begin
         dmem[a]     = (16'(a) * 16'h0101) ^ 16'h5a3c;
         ref_dmem[a] = dmem[a];
      end
      new_program();
      reset_and_fetch();
      arithmetic_ops();
      logic_ops();
      store_traffic();
      load_forwarding();
      unsupported_opcodes();
      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* sources.f */
+incdir+verilog
verilog/lc4_pkg.sv
verilog/lc4_decoder.sv
verilog/lc4_regfile.sv
verilog/lc4_alu.sv
verilog/lc4_processor.sv
dv/tb_lc4_processor.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the LC4 pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f sources.f \
   --top-module tb_lc4_processor \
   -Mdir obj_dir -o sim_lc4

./obj_dir/sim_lc4 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
   echo "Simulation reported failures"
   exit 1
fi
echo "Simulation finished without failures"
